//--- dv/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic btn_reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on an edge so cycle 0 is a clean edge
    initial begin
        btn_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        btn_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top import pet_pkg::*; #(
    parameter int TICK_DIV = 1_000_000
);

    localparam int LOCK_CYCLES = 2;
    localparam int COOLDOWN    = 6;
    localparam int DEPTH       = 4;
    localparam int MED_EVERY   = 3;
    localparam int MAX_CYCLES  = 200_000;
    // no tick inside the run, so menu and queue tests
    localparam bit SLOW_TICK   = (TICK_DIV > MAX_CYCLES);

    localparam int LEFT   = 0;
    localparam int RIGHT  = 1;
    localparam int ACTION = 2;
    localparam int CANCEL = 3;

    logic  clk;
    logic  btn_reset;
    logic  btn_left;
    logic  btn_right;
    logic  btn_action;
    logic  btn_cancel;
    need_t food;
    need_t fun;
    need_t rest;
    need_t life;
    need_t medicines;
    logic  disease;
    logic  death;
    mode_t mode;
    sel_t  sel;

    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    bit          hung = 1'b0;
    logic [31:0] lfsr = 32'h81bda090;

    // reference state
    int    m_food;
    int    m_fun;
    int    m_rest;
    int    m_life;
    int    m_meds;
    int    m_plays;
    sel_t  m_sel;
    mode_t m_mode;

    tb_clock #(
        .PERIOD       (100),
        .RESET_CYCLES (2)
    ) clock0 (
        .clk       (clk),
        .btn_reset (btn_reset)
    );

    pet_top #(
        .TICK_DIV    (TICK_DIV),
        .LOCK_CYCLES (LOCK_CYCLES),
        .COOLDOWN    (COOLDOWN),
        .DEPTH       (DEPTH),
        .MED_EVERY   (MED_EVERY)
    ) dut0 (
        .clk        (clk),
        .btn_reset  (btn_reset),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_action (btn_action),
        .btn_cancel (btn_cancel),
        .food       (food),
        .fun        (fun),
        .rest       (rest),
        .life       (life),
        .medicines  (medicines),
        .disease    (disease),
        .death      (death),
        .mode       (mode),
        .sel        (sel)
    );

    // cycle k leaves k+1 here
    always @(posedge clk) begin
        cycle_count <= btn_reset ? 0 : cycle_count + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic bit queue_idle();
        return !dut0.req_valid && !dut0.act_valid && dut0.act_ready;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic check_eq(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // parks this process, the watchdog ends the run
    task automatic stall(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic wait_cycle(input int target);
        int t;
        t = 0;
        while (cycle_count < target && t < TICK_DIV + 100) begin
            @(negedge clk);
            t++;
        end
        if (cycle_count < target) begin
            stall("the next tick");
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (!queue_idle() && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (!queue_idle()) begin
            stall("the action queue to drain");
        end
    endtask

    task automatic press(input int b, input int gap);
        @(posedge clk);
        case (b)
            LEFT:    btn_left <= 1'b1;
            RIGHT:   btn_right <= 1'b1;
            ACTION:  btn_action <= 1'b1;
            default: btn_cancel <= 1'b1;
        endcase
        @(posedge clk);
        btn_left   <= 1'b0;
        btn_right  <= 1'b0;
        btn_action <= 1'b0;
        btn_cancel <= 1'b0;
        repeat (LOCK_CYCLES - 1 + gap) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_levels();
        check_eq("food", food, m_food);
        check_eq("fun", fun, m_fun);
        check_eq("rest", rest, m_rest);
        check_eq("life", life, m_life);
        check_eq("medicines", medicines, m_meds);
        check_eq("disease", disease, m_life <= DISEASE_LEVEL);
        check_eq("death", death, m_life == 0);
    endtask

    task automatic move_sel(input int b);
        if (b == LEFT) begin
            if (m_sel == SEL_HEAL) begin
                m_sel = SEL_EAT;
            end else if (m_sel == SEL_EAT) begin
                m_sel = SEL_PLAY;
            end
        end else if (m_sel == SEL_PLAY) begin
            m_sel = SEL_EAT;
        end else if (m_sel == SEL_EAT && m_life <= DISEASE_LEVEL) begin
            m_sel = SEL_HEAL;
        end
        press(b, take_bits(2));
        check_eq("sel", sel, m_sel);
        check_eq("mode", mode, m_mode);
        if (m_life > DISEASE_LEVEL) begin
            check_eq("heal selected while healthy", sel == SEL_HEAL, 0);
        end
    endtask

    task automatic goto_sel(input sel_t target);
        for (int i = 0; i < 4 && m_sel != target; i++) begin
            move_sel((target > m_sel) ? RIGHT : LEFT);
        end
    endtask

    task automatic enter();
        case (m_sel)
            SEL_PLAY: m_mode = PLAY;
            SEL_EAT:  m_mode = EAT;
            default:  m_mode = HEAL;
        endcase
        press(ACTION, take_bits(2));
        check_eq("mode", mode, m_mode);
    endtask

    task automatic cancel();
        m_mode = MAIN;
        press(CANCEL, take_bits(2));
        check_eq("mode", mode, m_mode);
    endtask

    // presses faster than the cooldown, the queue takes up the slack
    task automatic queue_actions(input act_t a, input int k);
        for (int i = 0; i < k; i++) begin
            press(ACTION, 0);
            if (a == ACT_EAT) begin
                m_food = (m_food < 100) ? m_food + 1 : 100;
            end else if (a == ACT_PLAY) begin
                m_fun = (m_fun < 100) ? m_fun + 1 : 100;
                m_plays++;
                if (m_plays % MED_EVERY == 0 && m_meds < 127) begin
                    m_meds++;
                end
            end else if (m_meds > 0) begin
                m_life = (m_life + 20 > 100) ? 100 : m_life + 20;
                m_meds--;
            end
        end
    endtask

    // life sees the needs from before the tick
    task automatic model_tick(input int n);
        int minus;
        int plus;
        minus = int'(m_food <= 30) + int'(m_fun <= 30) + int'(m_rest <= 30);
        plus  = int'(m_food >= 70) + int'(m_fun >= 70) + int'(m_rest >= 70);
        m_life = m_life - minus;
        if (m_life < 0) begin
            m_life = 0;
        end
        m_life = (m_life + plus > 100) ? 100 : m_life + plus;
        if (n % 3 == 0 && m_food > 0) begin
            m_food--;
        end
        if (n % 4 == 0 && m_fun > 0) begin
            m_fun--;
        end
        if (n % 5 == 0 && m_rest > 0) begin
            m_rest--;
        end
    endtask

    task automatic action_tests();
        int k;
        repeat (16) begin
            case (take_bits(2))
                0:       move_sel(LEFT);
                1, 3:    move_sel(RIGHT);
                default: begin
                    enter();
                    cancel();
                end
            endcase
        end
        repeat (3) begin
            goto_sel(SEL_EAT);
            enter();
            k = 1 + take_bits(2);
            queue_actions(ACT_EAT, k);
            cancel();
            wait_drain();
            check_levels();
            goto_sel(SEL_PLAY);
            enter();
            k = 1 + take_bits(2);
            queue_actions(ACT_PLAY, k);
            cancel();
            wait_drain();
            check_levels();
        end
    endtask

    task automatic heal_tests();
        goto_sel(SEL_HEAL);
        enter();
        // two medicines in stock, the third heal finds none
        repeat (3) begin
            queue_actions(ACT_HEAL, 1);
            wait_drain();
            check_levels();
        end
        if (m_sel == SEL_HEAL && m_life > DISEASE_LEVEL) begin
            m_sel = SEL_EAT;
        end
        check_eq("sel", sel, m_sel);
        cancel();
    endtask

    task automatic decay_tests();
        int n;
        bit healed;
        enter();
        repeat (2) begin
            queue_actions(ACT_PLAY, 3);
            wait_drain();
        end
        cancel();
        check_levels();
        check_eq("setup finished before first tick", cycle_count <= TICK_DIV, 1);
        healed = 1'b0;
        n = 0;
        while (m_life > 0 && n < 400) begin
            n++;
            wait_cycle(n * TICK_DIV + 1);
            model_tick(n);
            check_levels();
            if (!healed && m_life <= DISEASE_LEVEL && m_life > 0) begin
                heal_tests();
                healed = 1'b1;
            end
        end
        check_eq("death", death, 1);
        @(negedge clk);
        check_eq("mode", mode, DEATH);
    endtask

    initial begin
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_action = 1'b0;
        btn_cancel = 1'b0;
        m_food  = FOOD_INIT;
        m_fun   = FUN_INIT;
        m_rest  = REST_INIT;
        m_life  = LIFE_INIT;
        m_meds  = 0;
        m_plays = 0;
        m_sel   = SEL_PLAY;
        m_mode  = MAIN;
        wait_cycle(1);
        check_levels();
        check_eq("mode", mode, MAIN);
        check_eq("sel", sel, SEL_PLAY);
        check_eq("req_valid", dut0.req_valid, 0);
        check_eq("act_valid", dut0.act_valid, 0);
        check_eq("act_ready", dut0.act_ready, 1);
        if (SLOW_TICK) begin
            action_tests();
        end else begin
            decay_tests();
        end
        finish_run();
    end

    initial begin
        while (!hung && cycle_count < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (!hung) begin
            $display("run went past %0d cycles without finishing", MAX_CYCLES);
            timeouts++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/pet_pkg.sv
hdl/menu_ctrl.sv
hdl/act_fifo.sv
hdl/pet_core.sv
hdl/pet_top.sv
dv/tb_clock.sv
dv/tb_top.sv

//--- hdl/act_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module act_fifo import pet_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic btn_reset,
    input  logic in_valid,
    input  act_t in_act,
    output logic in_ready,
    output logic out_valid,
    output act_t out_act,
    input  logic out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(DEPTH);

    act_t          mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != FULL);
    assign out_valid = (count != '0);
    assign out_act   = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_act;
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (btn_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/menu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module menu_ctrl import pet_pkg::*; #(
    parameter int LOCK_CYCLES = 4
) (
    input  logic  clk,
    input  logic  btn_reset,
    input  logic  btn_left,
    input  logic  btn_right,
    input  logic  btn_action,
    input  logic  btn_cancel,
    input  logic  disease,
    input  logic  death,
    input  logic  req_ready,
    output logic  req_valid,
    output act_t  req_act,
    output mode_t mode,
    output sel_t  sel
);

    localparam int LW = $clog2(LOCK_CYCLES + 2);

    logic [LW-1:0] lock_cnt;
    logic          any_btn;
    logic          take;
    logic          in_activity;
    logic          act_press;

    assign any_btn     = btn_left | btn_right | btn_action | btn_cancel;
    assign take        = any_btn && (lock_cnt == '0) && (mode != DEATH);
    assign in_activity = (mode == PLAY) || (mode == EAT) || (mode == HEAL);
    // cancel wins over action inside an activity
    assign act_press   = take && in_activity && btn_action && !btn_cancel;

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            lock_cnt <= '0;
        end else if (take) begin
            lock_cnt <= LW'(LOCK_CYCLES);
        end else if (lock_cnt != '0) begin
            lock_cnt <= lock_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            mode <= MAIN;
            sel  <= SEL_PLAY;
        end else if (death) begin
            mode <= DEATH;
        end else begin
            // heal entry disappears once the pet is well again
            if (sel == SEL_HEAL && !disease) begin
                sel <= SEL_EAT;
            end
            if (take) begin
                case (mode)
                    MAIN: begin
                        if (btn_action) begin
                            case (sel)
                                SEL_PLAY: mode <= PLAY;
                                SEL_EAT:  mode <= EAT;
                                default:  mode <= HEAL;
                            endcase
                        end else if (btn_left) begin
                            if (sel != SEL_PLAY) begin
                                sel <= (sel == SEL_HEAL) ? SEL_EAT : SEL_PLAY;
                            end
                        end else if (btn_right) begin
                            if (sel == SEL_PLAY) begin
                                sel <= SEL_EAT;
                            end else if (sel == SEL_EAT && disease) begin
                                sel <= SEL_HEAL;
                            end
                        end
                    end
                    PLAY, EAT, HEAL: begin
                        if (btn_cancel) begin
                            mode <= MAIN;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // one request in flight, later presses are dropped
    always_ff @(posedge clk) begin
        if (btn_reset) begin
            req_valid <= 1'b0;
        end else if (!req_valid) begin
            req_valid <= act_press;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (act_press && !req_valid) begin
            case (mode)
                PLAY:    req_act <= ACT_PLAY;
                EAT:     req_act <= ACT_EAT;
                default: req_act <= ACT_HEAL;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/pet_core.sv
`timescale 1ns/1ns
`default_nettype none

module pet_core import pet_pkg::*; #(
    parameter int TICK_DIV  = 1000,
    parameter int COOLDOWN  = 8,
    parameter int MED_EVERY = 4
) (
    input  logic  clk,
    input  logic  btn_reset,
    input  logic  act_valid,
    input  act_t  act_act,
    output logic  act_ready,
    output need_t food,
    output need_t fun,
    output need_t rest,
    output need_t life,
    output need_t medicines,
    output logic  disease,
    output logic  death
);

    localparam int PW = $clog2(TICK_DIV + 1);
    localparam int CW = $clog2(COOLDOWN + 2);
    localparam int MW = $clog2(MED_EVERY + 1);
    localparam int DIV_TICKS [3] = '{FOOD_TICKS, FUN_TICKS, REST_TICKS};

    logic [PW-1:0] presc;
    logic          tick;
    logic [2:0]    div_cnt [3];
    logic [2:0]    decay;
    logic [CW-1:0] cool;
    logic          accept;
    logic [MW-1:0] plays;
    logic [MW-1:0] plays_n;
    need_t         food_n;
    need_t         fun_n;
    need_t         rest_n;
    need_t         life_n;
    need_t         med_n;

    function automatic need_t dec_sat(need_t v);
        return (v == '0) ? v : v - 7'd1;
    endfunction

    function automatic need_t inc_sat(need_t v, need_t top);
        return (v >= top) ? top : v + 7'd1;
    endfunction

    // losses first, then gains, each clamped
    function automatic need_t life_step(need_t l, need_t f, need_t u, need_t r);
        logic [1:0] minus;
        logic [1:0] plus;
        need_t      down;
        need_t      up;
        minus = 2'(f <= LIFE_MINUS) + 2'(u <= LIFE_MINUS) + 2'(r <= LIFE_MINUS);
        plus  = 2'(f >= LIFE_PLUS) + 2'(u >= LIFE_PLUS) + 2'(r >= LIFE_PLUS);
        down  = (l > 7'(minus)) ? l - 7'(minus) : '0;
        up    = down + 7'(plus);
        return (up > NEED_MAX) ? NEED_MAX : up;
    endfunction

    // counts down so the first tick lands on cycle TICK_DIV
    assign tick = (presc == '0);

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            presc <= PW'(TICK_DIV);
        end else if (tick) begin
            presc <= PW'(TICK_DIV - 1);
        end else begin
            presc <= presc - 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            decay[i] = tick && (div_cnt[i] == 3'(DIV_TICKS[i] - 1));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (btn_reset || decay[i]) begin
                div_cnt[i] <= '0;
            end else if (tick) begin
                div_cnt[i] <= div_cnt[i] + 1'b1;
            end
        end
    end

    assign act_ready = (cool == '0);
    assign accept    = act_valid && act_ready;

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            cool <= '0;
        end else if (accept) begin
            cool <= CW'(COOLDOWN);
        end else if (cool != '0) begin
            cool <= cool - 1'b1;
        end
    end

    // tick result first, an accepted action lands on top of it
    always_comb begin
        food_n  = decay[0] ? dec_sat(food) : food;
        fun_n   = decay[1] ? dec_sat(fun) : fun;
        rest_n  = decay[2] ? dec_sat(rest) : rest;
        // life looks at the needs as they were before this tick
        life_n  = tick ? life_step(life, food, fun, rest) : life;
        med_n   = medicines;
        plays_n = plays;
        if (accept) begin
            case (act_act)
                ACT_PLAY: begin
                    fun_n = inc_sat(fun_n, NEED_MAX);
                    if (plays == MW'(MED_EVERY - 1)) begin
                        plays_n = '0;
                        med_n   = inc_sat(medicines, MED_MAX);
                    end else begin
                        plays_n = plays + 1'b1;
                    end
                end
                ACT_EAT: begin
                    food_n = inc_sat(food_n, NEED_MAX);
                end
                ACT_HEAL: begin
                    if (medicines != '0) begin
                        life_n = (life_n > NEED_MAX - HEAL_AMOUNT) ? NEED_MAX
                                                                   : life_n + HEAL_AMOUNT;
                        med_n  = medicines - 7'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            food      <= FOOD_INIT;
            fun       <= FUN_INIT;
            rest      <= REST_INIT;
            life      <= LIFE_INIT;
            medicines <= '0;
            plays     <= '0;
            disease   <= 1'b0;
            death     <= 1'b0;
        end else begin
            food      <= food_n;
            fun       <= fun_n;
            rest      <= rest_n;
            life      <= life_n;
            medicines <= med_n;
            plays     <= plays_n;
            disease   <= (life_n <= DISEASE_LEVEL);
            death     <= (life_n == '0);
        end
    end

endmodule

`default_nettype wire

//--- hdl/pet_pkg.sv
`default_nettype none

package pet_pkg;

    // needs and life run 0..100, medicines up to 127
    typedef logic [6:0] need_t;

    typedef enum logic [2:0] {MAIN, PLAY, EAT, HEAL, DEATH} mode_t;

    typedef enum logic [1:0] {ACT_PLAY, ACT_EAT, ACT_HEAL} act_t;

    typedef enum logic [1:0] {SEL_PLAY, SEL_EAT, SEL_HEAL} sel_t;

    localparam need_t NEED_MAX      = 7'd100;
    localparam need_t LIFE_MINUS    = 7'd30;
    localparam need_t LIFE_PLUS     = 7'd70;
    localparam need_t DISEASE_LEVEL = 7'd20;
    localparam need_t HEAL_AMOUNT   = 7'd20;
    localparam need_t MED_MAX       = 7'd127;

    localparam need_t FOOD_INIT = 7'd50;
    localparam need_t FUN_INIT  = 7'd50;
    localparam need_t REST_INIT = 7'd50;
    localparam need_t LIFE_INIT = 7'd100;

    // ticks per decay step
    localparam int FOOD_TICKS = 3;
    localparam int FUN_TICKS  = 4;
    localparam int REST_TICKS = 5;

endpackage

`default_nettype wire

//--- hdl/pet_top.sv
`timescale 1ns/1ns
`default_nettype none

module pet_top import pet_pkg::*; #(
    parameter int TICK_DIV    = 50_000_000,
    parameter int LOCK_CYCLES = 10_000_000,
    parameter int COOLDOWN    = 25_000_000,
    parameter int DEPTH       = 4,
    parameter int MED_EVERY   = 5
) (
    input  logic  clk,
    input  logic  btn_reset,
    input  logic  btn_left,
    input  logic  btn_right,
    input  logic  btn_action,
    input  logic  btn_cancel,
    output need_t food,
    output need_t fun,
    output need_t rest,
    output need_t life,
    output need_t medicines,
    output logic  disease,
    output logic  death,
    output mode_t mode,
    output sel_t  sel
);

    logic req_valid;
    logic req_ready;
    act_t req_act;
    logic act_valid;
    logic act_ready;
    act_t act_act;

    // buttons to requests
    menu_ctrl #(
        .LOCK_CYCLES(LOCK_CYCLES)
    ) menu0 (
        .clk        (clk),
        .btn_reset  (btn_reset),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_action (btn_action),
        .btn_cancel (btn_cancel),
        .disease    (disease),
        .death      (death),
        .req_ready  (req_ready),
        .req_valid  (req_valid),
        .req_act    (req_act),
        .mode       (mode),
        .sel        (sel)
    );

    act_fifo #(
        .DEPTH(DEPTH)
    ) fifo0 (
        .clk       (clk),
        .btn_reset (btn_reset),
        .in_valid  (req_valid),
        .in_act    (req_act),
        .in_ready  (req_ready),
        .out_valid (act_valid),
        .out_act   (act_act),
        .out_ready (act_ready)
    );

    // needs, life and medicine stock
    pet_core #(
        .TICK_DIV  (TICK_DIV),
        .COOLDOWN  (COOLDOWN),
        .MED_EVERY (MED_EVERY)
    ) core0 (
        .clk       (clk),
        .btn_reset (btn_reset),
        .act_valid (act_valid),
        .act_act   (act_act),
        .act_ready (act_ready),
        .food      (food),
        .fun       (fun),
        .rest      (rest),
        .life      (life),
        .medicines (medicines),
        .disease   (disease),
        .death     (death)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# two elaborations: slow ticks for menu and queue tests, fast ticks for decay and heal
cd "$(dirname "$0")" || exit 1

status=0
for td in 1000000 400; do
    mdir="obj_td$td"
    log="sim_td$td.log"
    verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
        --top-module tb_top -GTICK_DIV=$td --Mdir "$mdir" -f filelist.f
    if [ $? -ne 0 ]; then
        echo "build failed for TICK_DIV=$td"
        exit 1
    fi
    "./$mdir/Vtb_top" > "$log" 2>&1
    if [ $? -ne 0 ]; then
        echo "simulation exited with an error for TICK_DIV=$td"
        status=1
    fi
    cat "$log"
    if ! grep -q "^=== PASS ===$" "$log"; then
        status=1
    fi
done
exit $status
